// ==== mtsp_pkg.sv ====
// shared widths and structs for the load path; referenced by scoped names from every block
package mtsp_pkg;

	// ====================
	// data and address widths
	// ====================

	// one bus / memory data word
	typedef logic [31:0] dword_t;
	// global byte address, reads step by 4
	typedef logic [31:0] gaddr_t;
	// local memory dword index, wraps at 1024
	typedef logic [9:0]  laddr_t;
	// dwords per command, zero means nothing to move
	typedef logic [7:0]  count_t;

	// ====================
	// command and bus structs
	// ====================

	// load command, 50 bits
	typedef struct packed {
		gaddr_t gaddr;
		laddr_t laddr;
		count_t count;
	} load_cmd_t;

	// master read request, one cycle of req per read
	typedef struct packed {
		logic   req;
		gaddr_t addr;
	} bus_rd_t;

	// master read response, in order, one valid pulse per request
	typedef struct packed {
		logic   valid;
		dword_t data;
	} bus_rsp_t;

	// local memory write port
	typedef struct packed {
		logic   we;
		laddr_t addr;
		dword_t data;
	} lm_wr_t;

	// read queue entry, 43 bits
	typedef struct packed {
		laddr_t laddr;
		dword_t data;
		logic   last;
	} qentry_t;

	// fetch engine states
	typedef enum logic {
		FETCH_IDLE,
		FETCH_RUN
	} fetch_state_t;

endpackage

// ==== mtsp_fetch.sv ====
// fetch engine: takes a load command, issues global reads under a credit limit, tags the data
module mtsp_fetch #(
	parameter int QUEUE_DEPTH = 8,
	localparam int LVL_W = $clog2(QUEUE_DEPTH + 1)
) (
	input  logic                   CLK,
	input  logic                   rst,
	// command side
	input  logic                   start,
	input  mtsp_pkg::load_cmd_t    cmd,
	// master bus
	output mtsp_pkg::bus_rd_t      bus_rd,
	input  mtsp_pkg::bus_rsp_t     bus_rsp,
	// read queue side
	input  logic [LVL_W-1:0]       q_level,
	output logic                   q_push,
	output mtsp_pkg::qentry_t      q_entry,
	// busy contribution
	output logic                   active
);

	// ====================
	// state and counters
	// ====================

	mtsp_pkg::fetch_state_t state;
	// next global read address
	mtsp_pkg::gaddr_t       rd_addr;
	// requests still to issue
	mtsp_pkg::count_t       req_left;
	// responses still expected
	mtsp_pkg::count_t       rsp_left;
	// local address of the next response
	mtsp_pkg::laddr_t       rsp_laddr;
	// requests on the bus without a response yet
	logic [LVL_W-1:0]       outstanding;
	// queue slots already spoken for
	logic [LVL_W:0]         credit_used;
	logic                   idle;
	logic                   accept;
	logic                   issue;
	logic                   rsp_take;
	logic                   rsp_last;

	// idle only once the last entry has left the push register
	assign idle = (state == mtsp_pkg::FETCH_IDLE) && !q_push;
	// zero count start is dropped
	assign accept = start && idle && (cmd.count != '0);

	// credit: in flight + registered push + queue fill
	assign credit_used = {1'b0, outstanding} + {1'b0, q_level} + {{LVL_W{1'b0}}, q_push};

	// one read per cycle while credit remains
	assign issue = (state == mtsp_pkg::FETCH_RUN) && (req_left != '0) &&
		(credit_used < (LVL_W + 1)'(QUEUE_DEPTH));

	assign rsp_take = bus_rsp.valid && (state == mtsp_pkg::FETCH_RUN);
	assign rsp_last = rsp_take && (rsp_left == 8'd1);

	// request straight from the counters
	assign bus_rd.req  = issue;
	assign bus_rd.addr = rd_addr;

	// covers the cycle the last entry is pushed
	assign active = (state == mtsp_pkg::FETCH_RUN) | q_push;

	// ====================
	// FSM
	// ====================

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= mtsp_pkg::FETCH_IDLE;
		end else begin
			case (state)
				mtsp_pkg::FETCH_IDLE: begin
					if (accept) begin
						state <= mtsp_pkg::FETCH_RUN;
					end
				end
				mtsp_pkg::FETCH_RUN: begin
					// done when the final response is in
					if (rsp_last) begin
						state <= mtsp_pkg::FETCH_IDLE;
					end
				end
				default: begin
					state <= mtsp_pkg::FETCH_IDLE;
				end
			endcase
		end
	end

	// request / response counts and credit
	always_ff @(posedge CLK) begin
		if (rst) begin
			req_left    <= '0;
			rsp_left    <= '0;
			outstanding <= '0;
		end else if (accept) begin
			req_left    <= cmd.count;
			rsp_left    <= cmd.count;
			outstanding <= '0;
		end else begin
			if (issue) begin
				req_left <= req_left - 8'd1;
			end
			if (rsp_take) begin
				rsp_left <= rsp_left - 8'd1;
			end
			// request and response in one cycle cancel out
			case ({issue, rsp_take})
				2'b10:   outstanding <= outstanding + LVL_W'(1);
				2'b01:   outstanding <= outstanding - LVL_W'(1);
				default: outstanding <= outstanding;
			endcase
		end
	end

	// address counters
	always_ff @(posedge CLK) begin
		if (accept) begin
			rd_addr   <= cmd.gaddr;
			rsp_laddr <= cmd.laddr;
		end else begin
			if (issue) begin
				rd_addr <= rd_addr + 32'd4;
			end
			// local index wraps at 1024 by width
			if (rsp_take) begin
				rsp_laddr <= rsp_laddr + 10'd1;
			end
		end
	end

	// ====================
	// push to queue
	// ====================

	always_ff @(posedge CLK) begin
		if (rst) begin
			q_push <= 1'b0;
		end else begin
			q_push <= rsp_take;
		end
	end

	// tag data with local address and last flag
	always_ff @(posedge CLK) begin
		if (rsp_take) begin
			q_entry.laddr <= rsp_laddr;
			q_entry.data  <= bus_rsp.data;
			q_entry.last  <= rsp_last;
		end
	end

endmodule

// ==== mtsp_read_queue.sv ====
// read queue between the fetch engine and the local writer; head always visible, fill level out
module mtsp_read_queue #(
	parameter int QUEUE_DEPTH = 8,
	localparam int LVL_W = $clog2(QUEUE_DEPTH + 1),
	localparam int PTR_W = $clog2(QUEUE_DEPTH)
) (
	input  logic                 CLK,
	input  logic                 rst,
	// write side
	input  logic                 push,
	input  mtsp_pkg::qentry_t    din,
	// read side
	input  logic                 pop,
	output mtsp_pkg::qentry_t    dout,
	output logic                 empty,
	// fill level for credit counting
	output logic [LVL_W-1:0]     level
);

	// ====================
	// storage
	// ====================

	mtsp_pkg::qentry_t mem [QUEUE_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	// pop on empty is dropped
	logic              do_pop;

	// circular step, works for any depth
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + PTR_W'(1);
		end
		return nxt;
	endfunction

	assign empty  = (level == '0);
	assign do_pop = pop && !empty;
	// head entry, shown whether popped or not
	assign dout   = mem[rd_ptr];

	// write port
	always_ff @(posedge CLK) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	// ====================
	// pointers and level
	// ====================

	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			// push and pop together keep the level
			case ({push, do_pop})
				2'b10:   level <= level + LVL_W'(1);
				2'b01:   level <= level - LVL_W'(1);
				default: level <= level;
			endcase
		end
	end

endmodule

// ==== mtsp_local_write.sv ====
// local memory writer: drains the read queue into the local write port and flags completion
module mtsp_local_write (
	input  logic                 CLK,
	input  logic                 rst,
	// read queue side
	input  logic                 q_empty,
	input  mtsp_pkg::qentry_t    q_head,
	output logic                 q_pop,
	// local memory port
	output mtsp_pkg::lm_wr_t     lm_wr,
	input  logic                 lm_wait,
	// completion and busy
	output logic                 intr,
	output logic                 active
);

	// ====================
	// output register
	// ====================

	// register holds an entry
	logic             wr_we;
	mtsp_pkg::laddr_t wr_addr;
	mtsp_pkg::dword_t wr_data;
	// entry is the last of its command
	logic             wr_last;
	// write taken by local memory this cycle
	logic             accept;
	// register can load this cycle
	logic             free;

	assign accept = wr_we && !lm_wait;
	// empty, or emptied by this accept
	assign free   = !wr_we || accept;
	// back-to-back refill
	assign q_pop  = !q_empty && free;

	assign lm_wr.we   = wr_we;
	assign lm_wr.addr = wr_addr;
	assign lm_wr.data = wr_data;

	assign active = wr_we;

	// valid bit and completion pulse
	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_we <= 1'b0;
			intr  <= 1'b0;
		end else begin
			if (q_pop) begin
				wr_we <= 1'b1;
			end else if (accept) begin
				wr_we <= 1'b0;
			end
			// one cycle after the last write is taken
			intr <= accept && wr_last;
		end
	end

	// ====================
	// payload
	// ====================

	// only loads on pop, so lm_wait holds it steady
	always_ff @(posedge CLK) begin
		if (q_pop) begin
			wr_addr <= q_head.laddr;
			wr_data <= q_head.data;
			wr_last <= q_head.last;
		end
	end

endmodule

// ==== mtsp_load_unit.sv ====
// load unit top: global memory to local memory block copy, fetch + read queue + local writer
module mtsp_load_unit #(
	parameter int QUEUE_DEPTH = 8
) (
	// system
	input  logic                  CLK,
	input  logic                  rst,
	// load command
	input  logic                  start,
	input  mtsp_pkg::load_cmd_t   cmd,
	// master bus
	output mtsp_pkg::bus_rd_t     bus_rd,
	input  mtsp_pkg::bus_rsp_t    bus_rsp,
	// local memory
	output mtsp_pkg::lm_wr_t      lm_wr,
	input  logic                  lm_wait,
	// status
	output logic                  busy,
	output logic                  intr
);

	localparam int LVL_W = $clog2(QUEUE_DEPTH + 1);

	// ====================
	// internal wiring
	// ====================

	// fetch to queue
	logic                  q_push;
	mtsp_pkg::qentry_t     q_entry;
	logic [LVL_W-1:0]      q_level;
	// queue to writer
	logic                  q_empty;
	mtsp_pkg::qentry_t     q_head;
	logic                  q_pop;
	// per-block activity
	logic                  fetch_active;
	logic                  write_active;

	// any entry anywhere in the path
	assign busy = fetch_active | ~q_empty | write_active;

	// producer
	mtsp_fetch #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) i_fetch (
		.CLK     (CLK),
		.rst     (rst),
		.start   (start),
		.cmd     (cmd),
		.bus_rd  (bus_rd),
		.bus_rsp (bus_rsp),
		.q_level (q_level),
		.q_push  (q_push),
		.q_entry (q_entry),
		.active  (fetch_active)
	);

	// read queue
	mtsp_read_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) i_read_queue (
		.CLK   (CLK),
		.rst   (rst),
		.push  (q_push),
		.din   (q_entry),
		.pop   (q_pop),
		.dout  (q_head),
		.empty (q_empty),
		.level (q_level)
	);

	// consumer
	mtsp_local_write i_local_write (
		.CLK     (CLK),
		.rst     (rst),
		.q_empty (q_empty),
		.q_head  (q_head),
		.q_pop   (q_pop),
		.lm_wr   (lm_wr),
		.lm_wait (lm_wait),
		.intr    (intr),
		.active  (write_active)
	);

endmodule

// ==== tb_mtsp_load_unit.sv ====
// load unit testbench with bus and local memory models, used as the simulation top
module tb_mtsp_load_unit;

	localparam int QUEUE_DEPTH = 4;
	localparam int N_ROWS      = 7;
	localparam int RST_CYCLES  = 5;

	// ====================
	// DUT signals
	// ====================

	logic                CLK;
	logic                rst;
	logic                start;
	mtsp_pkg::load_cmd_t cmd;
	mtsp_pkg::bus_rd_t   bus_rd;
	mtsp_pkg::bus_rsp_t  bus_rsp = '0;
	mtsp_pkg::lm_wr_t    lm_wr;
	logic                lm_wait = 1'b0;
	logic                busy;
	logic                intr;

	// ====================
	// command table
	// ====================

	// gaddr = global byte base, laddr = local dword base, count = dwords
	// slow = bus latency 4..6, dup = second start while busy
	mtsp_pkg::gaddr_t row_gaddr [N_ROWS] = '{32'h0000_1000, 32'h0000_2040, 32'h0001_0000,
		32'h0000_3000, 32'h0000_4000, 32'h0002_0100, 32'hFFFF_FFE0};
	mtsp_pkg::laddr_t row_laddr [N_ROWS] = '{10'd0, 10'd100, 10'd200, 10'd50, 10'd1020,
		10'd512, 10'd1023};
	mtsp_pkg::count_t row_count [N_ROWS] = '{8'd4, 8'd1, 8'd16, 8'd0, 8'd8, 8'd7, 8'd6};
	logic             row_slow  [N_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
	logic             row_dup   [N_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};

	// command in progress, set by the sequencer
	mtsp_pkg::gaddr_t act_gaddr = '0;
	mtsp_pkg::laddr_t act_laddr = '0;
	int               act_count = 0;
	logic             act_slow  = 1'b0;
	int               act_seq   = 0;

	// model state
	int               pend_due[$];
	mtsp_pkg::dword_t pend_data[$];
	int               last_due    = 0;
	logic [31:0]      rng         = 32'h1327;
	int               seen_seq    = 0;
	int               req_idx     = 0;
	int               wr_idx      = 0;
	logic             expect_idle = 1'b1;
	logic             intr_exp    = 1'b0;
	int               intr_count  = 0;
	logic             held        = 1'b0;
	mtsp_pkg::lm_wr_t prev_wr     = '0;
	int               cycle       = 0;
	int               limit       = 0;

	mtsp_load_unit #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) i_dut (
		.CLK     (CLK),
		.rst     (rst),
		.start   (start),
		.cmd     (cmd),
		.bus_rd  (bus_rd),
		.bus_rsp (bus_rsp),
		.lm_wr   (lm_wr),
		.lm_wait (lm_wait),
		.busy    (busy),
		.intr    (intr)
	);

	// ====================
	// helpers
	// ====================

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// global memory contents
	function automatic mtsp_pkg::dword_t gmem_word(input mtsp_pkg::gaddr_t a);
		return a ^ 32'hA5A5_0000;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic fail_run(input string why);
		$display("ERROR time=%0t %s", $time, why);
		$display("Test failed");
		$fatal(1, "%s", why);
	endtask

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// cycle count and run limit
	always @(posedge CLK) begin
		cycle <= cycle + 1;
		if (cycle >= limit) begin
			fail_run("run did not finish within the cycle limit");
		end
	end

	// ====================
	// bus and local memory model
	// ====================

	always @(negedge CLK) begin : model
		mtsp_pkg::gaddr_t exp_gaddr;
		mtsp_pkg::laddr_t exp_addr;
		logic [31:0]      lat;
		int               due;
		if (cycle > RST_CYCLES) begin
			// new command from the sequencer
			if (act_seq != seen_seq) begin
				seen_seq    = act_seq;
				req_idx     = 0;
				wr_idx      = 0;
				expect_idle = 1'b0;
			end
			// intr only right after the last accepted write
			check_value("intr", 64'(intr), 64'(intr_exp));
			intr_exp = 1'b0;
			if (intr) begin
				intr_count  = intr_count + 1;
				expect_idle = 1'b1;
			end
			// write port frozen while lm_wait was high
			if (held) begin
				check_value("lm_wr", 64'(lm_wr), 64'(prev_wr));
			end
			// nothing moves between commands
			if (expect_idle) begin
				check_value("busy", 64'(busy), 64'd0);
				check_value("bus_rd.req", 64'(bus_rd.req), 64'd0);
				check_value("lm_wr.we", 64'(lm_wr.we), 64'd0);
			end
			// in-order response when due
			bus_rsp.valid = 1'b0;
			if (pend_due.size() != 0 && pend_due[0] == cycle) begin
				void'(pend_due.pop_front());
				bus_rsp.valid = 1'b1;
				bus_rsp.data  = pend_data.pop_front();
			end
			// request taken at the next rising edge
			if (bus_rd.req) begin
				if (req_idx >= act_count) begin
					fail_run("bus read issued beyond the command count");
				end
				exp_gaddr = act_gaddr + mtsp_pkg::gaddr_t'(4 * req_idx);
				check_value("bus_rd.addr", 64'(bus_rd.addr), 64'(exp_gaddr));
				rng = lcg_next(rng);
				if (act_slow) begin
					lat = 32'd4 + ((rng >> 16) % 32'd3);
				end else begin
					lat = 32'd1 + ((rng >> 16) % 32'd6);
				end
				// never overtake an earlier response
				due = cycle + int'(lat);
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				pend_due.push_back(due);
				pend_data.push_back(gmem_word(bus_rd.addr));
				if (pend_due.size() > QUEUE_DEPTH) begin
					fail_run("more bus reads outstanding than the queue depth allows");
				end
				req_idx = req_idx + 1;
			end
			// lm_wait high about one cycle in three
			rng     = lcg_next(rng);
			lm_wait = ((rng >> 16) % 32'd3) == 32'd0;
			held    = lm_wr.we && lm_wait;
			prev_wr = lm_wr;
			// write accepted at the next rising edge
			if (lm_wr.we && !lm_wait) begin
				if (wr_idx >= act_count) begin
					fail_run("local write beyond the command count");
				end
				exp_addr  = act_laddr + mtsp_pkg::laddr_t'(wr_idx);
				exp_gaddr = act_gaddr + mtsp_pkg::gaddr_t'(4 * wr_idx);
				check_value("lm_wr.addr", 64'(lm_wr.addr), 64'(exp_addr));
				check_value("lm_wr.data", 64'(lm_wr.data), 64'(gmem_word(exp_gaddr)));
				if (wr_idx == act_count - 1) begin
					intr_exp = 1'b1;
				end
				wr_idx = wr_idx + 1;
			end
		end
	end

	// ====================
	// sequencer
	// ====================

	initial begin : sequencer
		int total;
		int done;
		total = 0;
		done  = 0;
		for (int i = 0; i < N_ROWS; i++) begin
			total = total + int'(row_count[i]);
		end
		limit = 40 * total + 200;
		rst   = 1'b1;
		start = 1'b0;
		cmd   = '0;
		repeat (RST_CYCLES) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;
		for (int r = 0; r < N_ROWS; r++) begin
			@(negedge CLK);
			start     = 1'b1;
			cmd.gaddr = row_gaddr[r];
			cmd.laddr = row_laddr[r];
			cmd.count = row_count[r];
			if (row_count[r] != 8'd0) begin
				act_gaddr = row_gaddr[r];
				act_laddr = row_laddr[r];
				act_count = int'(row_count[r]);
				act_slow  = row_slow[r];
				act_seq   = act_seq + 1;
			end
			@(negedge CLK);
			start = 1'b0;
			if (row_count[r] == 8'd0) begin
				// dropped command leaves the path quiet
				repeat (20) @(negedge CLK);
			end else begin
				check_value("busy", 64'(busy), 64'd1);
				if (row_dup[r]) begin
					// start while busy is ignored
					repeat (3) @(negedge CLK);
					start     = 1'b1;
					cmd.gaddr = 32'h00BA_D000;
					cmd.laddr = 10'd7;
					cmd.count = 8'd3;
					@(negedge CLK);
					start = 1'b0;
				end
				done = done + 1;
				while (intr_count != done) begin
					@(posedge CLK);
				end
			end
		end
		// quiet tail
		repeat (10) @(negedge CLK);
		@(posedge CLK);
		$display("Test passed");
		$finish;
	end

endmodule

// ==== build.f ====
mtsp_pkg.sv
mtsp_fetch.sv
mtsp_read_queue.sv
mtsp_local_write.sv
mtsp_load_unit.sv
tb_mtsp_load_unit.sv

// ==== Makefile ====
TOP  := tb_mtsp_load_unit
SIM  := obj_dir/V$(TOP)
SRCS := $(shell cat build.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) build.f
	verilator --binary --timing -j 0 --top-module $(TOP) -f build.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
